/* tests/xike_testdata.txt */
# W addr data | R addr expected | S stream ch data | E ch diff  (all hex)
# D words (dec) | F count(dec) ch base step(dec) host_words(dec) internal_cap(dec)
R 00 0000
R 01 0000
# Disabled input, no words and no drops
S 0 003 7777
S 1 003 7777
S 2 003 7777
S 3 003 7777
S 4 003 7777
D 0
R 01 0000
W 00 0001
R 00 0001
# Two channels, then channel 003 again against its history
S 0 003 1000
S 1 003 0200
S 2 003 0030
S 3 003 FFFF
S 4 003 0005
S 0 011 0100
S 1 011 0200
S 2 011 0300
S 3 011 0400
S 4 011 0500
E 003 01000
E 003 00200
E 003 00030
E 003 0FFFF
E 003 00005
E 011 00100
E 011 00200
E 011 00300
E 011 00400
E 011 00500
S 0 003 0F00
S 1 003 0250
S 2 003 0030
S 3 003 0001
S 4 003 8005
E 003 FFF00
E 003 00050
E 003 00000
E 003 F0002
E 003 08000
# Streams 5 to 7 are discarded
S 0 007 0010
S 5 007 1111
S 1 007 0020
S 6 007 2222
S 2 007 0030
S 3 007 0040
S 7 007 3333
D 0
S 4 007 0050
E 007 00010
E 007 00020
E 007 00030
E 007 00040
E 007 00050
# Flood, 64 host words plus 27 samples held inside
F 400 01A 2000 3 64 27
E 01A 02000
E 01A 02003
E 01A 02006
E 01A 02009
E 01A 0200C
E 01A 0000F
D 84
R 01 0135
R 00 0001

/* sources.f */
+incdir+common
common/xike_pkg.sv
rtl/sync_fifo.sv
rtl/xike_regs.sv
mua/raw_comb.sv
mua/mua_filter.sv
mua/mua_serializer.sv
rtl/xike_top.sv
tests/xike_assertions.sv
tests/xike_tb.sv

/* tests/xike_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "xike_macros.svh"

module xike_tb
  import xike_pkg::*;
();

  localparam int cycles_per_line = 200;
  localparam int settle_cycles   = 40;
  localparam     data_file       = "tests/xike_testdata.txt";

  logic                        bus_clk;
  logic                        reset;
  logic                        sample_valid;
  sample_t                     sample;
  logic                        reg_wren;
  logic                        reg_rden;
  logic [`XIKE_REG_ADDR_W-1:0] reg_addr;
  logic [15:0]                 reg_wdata;
  logic                        host_rden;
  logic [15:0]                 reg_rdata;
  host_word_t                  host_data;
  logic                        host_empty;

  int               fd;
  int               line_total;
  int               timeout_cycles;
  logic [8*160-1:0] line_buf;

  xike_top dut_i (
    .bus_clk     (bus_clk     ),
    .reset       (reset       ),
    .sample_valid(sample_valid),
    .sample      (sample      ),
    .reg_wren    (reg_wren    ),
    .reg_rden    (reg_rden    ),
    .reg_addr    (reg_addr    ),
    .reg_wdata   (reg_wdata   ),
    .host_rden   (host_rden   ),
    .reg_rdata   (reg_rdata   ),
    .host_data   (host_data   ),
    .host_empty  (host_empty  )
  );

  always #20 bus_clk = ~bus_clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s actual 0x%08h expected 0x%08h", name, actual, expected));
    end
  endtask

  task automatic require_fields(input int got, input int want, input logic [7:0] cmd);
    if (got != want) begin
      abort_run($sformatf("malformed %s line in the test data file", cmd));
    end
  endtask

  task automatic reg_write(input logic [`XIKE_REG_ADDR_W-1:0] addr, input logic [15:0] data);
    @(negedge bus_clk);
    reg_wren  = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge bus_clk);
    reg_wren = 1'b0;
  endtask

  // Read data is registered, so it is checked one cycle after the strobe
  task automatic reg_read(input logic [`XIKE_REG_ADDR_W-1:0] addr, input logic [15:0] expected);
    @(negedge bus_clk);
    reg_rden = 1'b1;
    reg_addr = addr;
    @(negedge bus_clk);
    reg_rden = 1'b0;
    check_value($sformatf("reg_rdata[%0d]", addr), reg_rdata, expected);
  endtask

  task automatic send_sample(input logic [`XIKE_STREAM_W-1:0] stream,
                             input logic [`XIKE_CH_W-1:0] ch,
                             input logic [`XIKE_DATA_W-1:0] data);
    @(negedge bus_clk);
    sample_valid  = 1'b1;
    sample.stream = stream;
    sample.ch     = ch;
    sample.data   = data;
    @(negedge bus_clk);
    sample_valid = 1'b0;
  endtask

  // FWFT head is compared before the pop
  task automatic pop_expected(input logic [31:0] expected);
    @(negedge bus_clk);
    while (host_empty) begin
      @(negedge bus_clk);
    end
    check_value("host_data", host_data, expected);
    host_rden = 1'b1;
    @(negedge bus_clk);
    host_rden = 1'b0;
  endtask

  task automatic drain_words(input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge bus_clk);
      while (host_empty) begin
        @(negedge bus_clk);
      end
      host_rden = 1'b1;
      @(negedge bus_clk);
      host_rden = 1'b0;
    end
    // Longer than the path from input buffer to host FIFO
    repeat (settle_cycles) @(negedge bus_clk);
    check_value("host_empty", host_empty, 1);
  endtask

  // Streams cycle 0 to 4 on one channel, data ramps by step
  task automatic flood_samples(input int count, input logic [`XIKE_CH_W-1:0] ch,
                               input logic [15:0] base, input int step,
                               input int host_words, input int internal_cap);
    int accepted;
    accepted = host_words + internal_cap;
    for (int k = 0; k < count; k++) begin
      send_sample(3'(k % `XIKE_NUM_STREAMS), ch, 16'(base + step * k));
    end
    reg_read(`XIKE_REG_OVF, 16'(count - accepted));
  endtask

  task automatic run_command(input logic [7:0] cmd);
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    logic [31:0] a4;
    logic [31:0] a5;
    int          n;
    case (cmd)
      "#": n = $fgets(line_buf, fd);
      "W": begin
        n = $fscanf(fd, "%h %h", a0, a1);
        require_fields(n, 2, cmd);
        reg_write(a0[`XIKE_REG_ADDR_W-1:0], a1[15:0]);
      end
      "R": begin
        n = $fscanf(fd, "%h %h", a0, a1);
        require_fields(n, 2, cmd);
        reg_read(a0[`XIKE_REG_ADDR_W-1:0], a1[15:0]);
      end
      "S": begin
        n = $fscanf(fd, "%h %h %h", a0, a1, a2);
        require_fields(n, 3, cmd);
        send_sample(a0[`XIKE_STREAM_W-1:0], a1[`XIKE_CH_W-1:0], a2[`XIKE_DATA_W-1:0]);
      end
      "E": begin
        n = $fscanf(fd, "%h %h", a0, a1);
        require_fields(n, 2, cmd);
        pop_expected({a0[`XIKE_CH_W-1:0], a1[`XIKE_DIFF_W-1:0]});
      end
      "D": begin
        n = $fscanf(fd, "%d", a0);
        require_fields(n, 1, cmd);
        drain_words(a0);
      end
      "F": begin
        n = $fscanf(fd, "%d %h %h %d %d %d", a0, a1, a2, a3, a4, a5);
        require_fields(n, 6, cmd);
        flood_samples(a0, a1[`XIKE_CH_W-1:0], a2[15:0], a3, a4, a5);
      end
      default: abort_run($sformatf("unknown command %s in the test data file", cmd));
    endcase
  endtask

  initial begin : main
    logic [7:0] cmd;
    int         n;
    bit         done;
    bus_clk      = 1'b0;
    reset        = 1'b1;
    sample_valid = 1'b0;
    sample       = '0;
    reg_wren     = 1'b0;
    reg_rden     = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    host_rden    = 1'b0;
    line_total   = 0;
    fd = $fopen(data_file, "r");
    if (fd == 0) begin
      abort_run("cannot open the test data file");
    end
    while (!$feof(fd)) begin
      if ($fgets(line_buf, fd) != 0) begin
        line_total++;
      end
    end
    $fclose(fd);
    timeout_cycles = (line_total + 1) * cycles_per_line;

    repeat (2) @(negedge bus_clk);
    reset = 1'b0;
    check_value("host_empty", host_empty, 1);

    fd   = $fopen(data_file, "r");
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", cmd);
      if (n != 1) begin
        done = 1'b1;
      end else begin
        run_command(cmd);
      end
    end
    $fclose(fd);
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin : watchdog
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge bus_clk);
    abort_run($sformatf("timeout: the run did not finish within %0d cycles", timeout_cycles));
  end

endmodule

`default_nettype wire

/* tests/xike_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module xike_assertions (
  input wire logic bus_clk,
  input wire logic reset,
  input wire logic host_empty,
  input wire logic comb_valid,
  input wire logic comb_ready,
  input wire logic in_empty,
  input wire logic mua_en
);

  // Host FIFO comes out of reset empty
  assert property (@(posedge bus_clk) reset |=> host_empty)
    else $error("host_empty low right after reset");

  // Combiner frame held until the filter takes it
  assert property (@(posedge bus_clk) disable iff (reset)
    comb_valid && !comb_ready |=> comb_valid)
    else $error("comb_valid dropped before the frame was accepted");

  // Disabled input leaves an empty buffer empty
  assert property (@(posedge bus_clk) disable iff (reset)
    !mua_en && in_empty |=> in_empty)
    else $error("input buffer written while the enable bit is low");

endmodule

bind xike_top xike_assertions i_xike_assertions (
  .bus_clk   (bus_clk   ),
  .reset     (reset     ),
  .host_empty(host_empty),
  .comb_valid(comb_valid),
  .comb_ready(comb_ready),
  .in_empty  (in_empty  ),
  .mua_en    (mua_en    )
);

`default_nettype wire

/* rtl/xike_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "xike_macros.svh"

module xike_top
  import xike_pkg::*;
(
  input  wire logic                        bus_clk,
  input  wire logic                        reset,
  input  wire logic                        sample_valid,
  input  wire sample_t                     sample,
  input  wire logic                        reg_wren,
  input  wire logic                        reg_rden,
  input  wire logic [`XIKE_REG_ADDR_W-1:0] reg_addr,
  input  wire logic [15:0]                 reg_wdata,
  input  wire logic                        host_rden,
  output logic      [15:0]                 reg_rdata,
  output host_word_t                       host_data,
  output logic                             host_empty
);

  logic        mua_en;
  logic        in_wren;
  logic        in_drop;
  logic        in_full;
  logic        in_empty;
  logic        in_rden;
  sample_t     in_sample;
  logic        comb_valid;
  logic        comb_ready;
  comb_frame_t comb_frame;
  logic        mua_valid;
  logic        mua_ready;
  mua_frame_t  mua_frame;
  logic        word_valid;
  host_word_t  word;
  logic        host_full;

  // Samples count as dropped only while enabled
  assign in_wren = sample_valid && mua_en && !in_full;
  assign in_drop = sample_valid && mua_en && in_full;

  xike_regs i_xike_regs (
    .bus_clk  (bus_clk  ),
    .reset    (reset    ),
    .reg_wren (reg_wren ),
    .reg_rden (reg_rden ),
    .reg_addr (reg_addr ),
    .reg_wdata(reg_wdata),
    .in_drop  (in_drop  ),
    .reg_rdata(reg_rdata),
    .mua_en   (mua_en   )
  );

  sync_fifo #(.payload_t(sample_t), .DEPTH(`XIKE_IN_DEPTH)) i_in_fifo (
    .bus_clk(bus_clk  ),
    .reset  (reset    ),
    .wr_en  (in_wren  ),
    .din    (sample   ),
    .rd_en  (in_rden  ),
    .dout   (in_sample),
    .full   (in_full  ),
    .empty  (in_empty )
  );

  raw_comb i_raw_comb (
    .bus_clk   (bus_clk   ),
    .reset     (reset     ),
    .in_sample (in_sample ),
    .in_empty  (in_empty  ),
    .comb_ready(comb_ready),
    .in_rden   (in_rden   ),
    .comb_valid(comb_valid),
    .comb_frame(comb_frame)
  );

  mua_filter i_mua_filter (
    .bus_clk   (bus_clk   ),
    .reset     (reset     ),
    .comb_valid(comb_valid),
    .comb_frame(comb_frame),
    .mua_ready (mua_ready ),
    .comb_ready(comb_ready),
    .mua_valid (mua_valid ),
    .mua_frame (mua_frame )
  );

  mua_serializer i_mua_serializer (
    .bus_clk   (bus_clk   ),
    .reset     (reset     ),
    .mua_valid (mua_valid ),
    .mua_frame (mua_frame ),
    .host_full (host_full ),
    .mua_ready (mua_ready ),
    .word_valid(word_valid),
    .word      (word      )
  );

  // Host side FIFO, first word fall through
  sync_fifo #(.payload_t(host_word_t), .DEPTH(`XIKE_HOST_DEPTH)) i_host_fifo (
    .bus_clk(bus_clk   ),
    .reset  (reset     ),
    .wr_en  (word_valid),
    .din    (word      ),
    .rd_en  (host_rden ),
    .dout   (host_data ),
    .full   (host_full ),
    .empty  (host_empty)
  );

endmodule

`default_nettype wire

/* mua/mua_serializer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "xike_macros.svh"

module mua_serializer
  import xike_pkg::*;
(
  input  wire logic       bus_clk,
  input  wire logic       reset,
  input  wire logic       mua_valid,
  input  wire mua_frame_t mua_frame,
  input  wire logic       host_full,
  output logic            mua_ready,
  output logic            word_valid,
  output host_word_t      word
);

  localparam int N  = `XIKE_NUM_STREAMS;
  localparam int CW = $clog2(N);

  logic          busy;
  logic [CW-1:0] lane_cnt;
  mua_frame_t    frame_q;

  // New frame only once the last lane is out
  assign mua_ready  = !busy;
  assign word_valid = busy && !host_full;
  assign word       = frame_q.lane[lane_cnt];

  always_ff @(posedge bus_clk) begin
    if (mua_valid && mua_ready) begin
      frame_q <= mua_frame;
    end
  end

  // Lane counter, holds while the host FIFO is full
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      busy     <= 1'b0;
      lane_cnt <= '0;
    end else if (mua_valid && mua_ready) begin
      busy     <= 1'b1;
      lane_cnt <= '0;
    end else if (word_valid) begin
      if (int'(lane_cnt) == N - 1) begin
        busy <= 1'b0;
      end else begin
        lane_cnt <= lane_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* mua/mua_filter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "xike_macros.svh"

module mua_filter
  import xike_pkg::*;
(
  input  wire logic        bus_clk,
  input  wire logic        reset,
  input  wire logic        comb_valid,
  input  wire comb_frame_t comb_frame,
  input  wire logic        mua_ready,
  output logic             comb_ready,
  output logic             mua_valid,
  output mua_frame_t       mua_frame
);

  localparam int N  = `XIKE_NUM_STREAMS;
  localparam int DW = `XIKE_DIFF_W;
  localparam int IW = $clog2(`XIKE_NUM_CH);

  logic [`XIKE_DATA_W-1:0]        hist [N][`XIKE_NUM_CH];
  logic [N-1:0][`XIKE_NUM_CH-1:0] hist_seen;
  logic [N-1:0][IW-1:0]           idx;
  logic                           advance;
  logic                           accept;
  logic                           s1_valid;
  comb_frame_t                    s1_frame;
  logic [N-1:0][`XIKE_DATA_W-1:0] s1_prev;

  // Unsigned samples widen with a zero sign bit before the subtract
  function automatic logic signed [DW-1:0] first_diff(input logic [`XIKE_DATA_W-1:0] cur,
                                                      input logic [`XIKE_DATA_W-1:0] prev);
    logic signed [DW-1:0] cur_ext;
    logic signed [DW-1:0] prev_ext;
    cur_ext  = signed'({{(DW - `XIKE_DATA_W){1'b0}}, cur});
    prev_ext = signed'({{(DW - `XIKE_DATA_W){1'b0}}, prev});
    return cur_ext - prev_ext;
  endfunction

  // Both stages freeze while the output frame is not taken
  assign advance    = !(mua_valid && !mua_ready);
  assign comb_ready = advance;
  assign accept     = comb_valid && comb_ready;

  always_comb begin
    for (int l = 0; l < N; l++) begin
      idx[l] = comb_frame.lane[l].ch[IW-1:0];
    end
  end

  // Stage 1 write back of the new sample
  always_ff @(posedge bus_clk) begin
    if (accept) begin
      for (int l = 0; l < N; l++) begin
        hist[l][idx[l]] <= comb_frame.lane[l].data;
      end
    end
  end

  // Entries never written count as 0
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      hist_seen <= '0;
    end else if (accept) begin
      for (int l = 0; l < N; l++) begin
        hist_seen[l][idx[l]] <= 1'b1;
      end
    end
  end

  // Stage 1 read of the old sample
  always_ff @(posedge bus_clk) begin
    if (advance) begin
      s1_frame <= comb_frame;
      for (int l = 0; l < N; l++) begin
        s1_prev[l] <= hist_seen[l][idx[l]] ? hist[l][idx[l]] : '0;
      end
    end
  end

  // Stage 2 difference
  always_ff @(posedge bus_clk) begin
    if (advance) begin
      for (int l = 0; l < N; l++) begin
        mua_frame.lane[l].ch   <= s1_frame.lane[l].ch;
        mua_frame.lane[l].diff <= first_diff(s1_frame.lane[l].data, s1_prev[l]);
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      mua_valid <= 1'b0;
    end else if (advance) begin
      s1_valid  <= comb_valid;
      mua_valid <= s1_valid;
    end
  end

endmodule

`default_nettype wire

/* mua/raw_comb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "xike_macros.svh"

module raw_comb
  import xike_pkg::*;
(
  input  wire logic    bus_clk,
  input  wire logic    reset,
  input  wire sample_t in_sample,
  input  wire logic    in_empty,
  input  wire logic    comb_ready,
  output logic         in_rden,
  output logic         comb_valid,
  output comb_frame_t  comb_frame
);

  localparam int N = `XIKE_NUM_STREAMS;

  logic [N-1:0] lane_wr;
  logic         frame_done;

  // Pop only while no finished frame waits downstream
  assign in_rden = !in_empty && !comb_valid;

  // Lane select by stream number
  // streams 5 to 7 hit no lane and are lost here
  always_comb begin
    for (int i = 0; i < N; i++) begin
      lane_wr[i] = in_rden && (int'(in_sample.stream) == i);
    end
  end

  // Last stream closes the frame
  assign frame_done = lane_wr[N-1];

  always_ff @(posedge bus_clk) begin
    for (int i = 0; i < N; i++) begin
      if (lane_wr[i]) begin
        comb_frame.lane[i].ch   <= in_sample.ch;
        comb_frame.lane[i].data <= in_sample.data;
      end
    end
  end

  // Held valid, dropped in the accepting cycle
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      comb_valid <= 1'b0;
    end else if (frame_done) begin
      comb_valid <= 1'b1;
    end else if (comb_valid && comb_ready) begin
      comb_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rtl/xike_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "xike_macros.svh"

module xike_regs (
  input  wire logic                        bus_clk,
  input  wire logic                        reset,
  input  wire logic                        reg_wren,
  input  wire logic                        reg_rden,
  input  wire logic [`XIKE_REG_ADDR_W-1:0] reg_addr,
  input  wire logic [15:0]                 reg_wdata,
  input  wire logic                        in_drop,
  output logic      [15:0]                 reg_rdata,
  output logic                             mua_en
);

  logic [15:0] ctrl_reg;
  logic [15:0] ovf_cnt;

  // Bit 0 gates the whole MUA input
  assign mua_en = ctrl_reg[0];

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      ctrl_reg <= '0;
    end else if (reg_wren && (reg_addr == `XIKE_REG_CTRL)) begin
      ctrl_reg <= reg_wdata;
    end
  end

  // Dropped samples, sticks at all ones
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      ovf_cnt <= '0;
    end else if (in_drop && (ovf_cnt != '1)) begin
      ovf_cnt <= ovf_cnt + 1'b1;
    end
  end

  // Read data lands one cycle after the strobe
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      reg_rdata <= '0;
    end else if (reg_rden) begin
      case (reg_addr)
        `XIKE_REG_CTRL: reg_rdata <= ctrl_reg;
        `XIKE_REG_OVF:  reg_rdata <= ovf_cnt;
        default:        reg_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  wire logic     bus_clk,
  input  wire logic     reset,
  input  wire logic     wr_en,
  input  wire payload_t din,
  input  wire logic     rd_en,
  output payload_t      dout,
  output logic          full,
  output logic          empty
);

  localparam int AW = $clog2(DEPTH);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_wr;
  logic          do_rd;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (int'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
  endfunction

  // Requests against a full or empty buffer are ignored
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;
  assign full  = (int'(count) == DEPTH);
  assign empty = (count == '0);

  // Head word visible without a read
  assign dout = mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* common/xike_pkg.sv */
`default_nettype none
`include "xike_macros.svh"

package xike_pkg;

  // Tagged amplifier sample as it leaves the acquisition side
  typedef struct packed {
    logic [`XIKE_STREAM_W-1:0] stream;
    logic [`XIKE_CH_W-1:0]     ch;
    logic [`XIKE_DATA_W-1:0]   data;
  } sample_t;

  typedef struct packed {
    logic [`XIKE_CH_W-1:0]   ch;
    logic [`XIKE_DATA_W-1:0] data;
  } comb_lane_t;

  // One lane per stream, lane 0 in the low bits
  typedef struct packed {
    comb_lane_t [`XIKE_NUM_STREAMS-1:0] lane;
  } comb_frame_t;

  // Host word layout, channel on top
  typedef struct packed {
    logic [`XIKE_CH_W-1:0]          ch;
    logic signed [`XIKE_DIFF_W-1:0] diff;
  } host_word_t;

  // Filtered lanes already carry the host word layout
  typedef struct packed {
    host_word_t [`XIKE_NUM_STREAMS-1:0] lane;
  } mua_frame_t;

endpackage

`default_nettype wire

/* common/xike_macros.svh */
`ifndef XIKE_MACROS_SVH
`define XIKE_MACROS_SVH

// Amplifier streams and channels per stream
`define XIKE_NUM_STREAMS 5
`define XIKE_NUM_CH      32
`define XIKE_STREAM_W    3

// Data path widths
`define XIKE_DATA_W      16
`define XIKE_CH_W        12
`define XIKE_DIFF_W      20

// Buffer depths
`define XIKE_IN_DEPTH    16
`define XIKE_HOST_DEPTH  64

// Register map
`define XIKE_REG_ADDR_W  5
`define XIKE_REG_CTRL    5'd0
`define XIKE_REG_OVF     5'd1

`endif
